// File: design/video_capture_pkg.sv
`default_nettype none

package video_capture_pkg;

    ////////////////////////////////////////////////////////////
    // raster and frame geometry
    ////////////////////////////////////////////////////////////

    // free-run timing
    localparam int raw_width  = 1716;
    localparam int raw_height = 525;

    // last line index of each known frame length
    localparam int lines_240p = 262;
    localparam int lines_480  = 524;
    localparam int lines_pal  = 624;

    // window table, 240p and PAL share the horizontal start
    localparam int hstart_240p = 257;
    localparam int hstart_480  = 265;
    localparam int vstart_240p = 18;
    localparam int vstart_pal  = 19;
    localparam int vstart_480  = 40;
    localparam int area_width  = 720;
    localparam int height_240p = 504;
    localparam int height_pal  = 600;
    localparam int height_480  = 480;

    ////////////////////////////////////////////////////////////
    // colour bars
    ////////////////////////////////////////////////////////////

    localparam int bar_offset = 40;
    localparam int bar_width  = 80;
    localparam int bar_level  = 255;

    // {r,g,b} mask per bar, entry 0 is the leftmost bar (red)
    localparam logic [7:0][2:0] bar_colours = {
        3'b101, 3'b110, 3'b011, 3'b000, 3'b111, 3'b001, 3'b010, 3'b100
    };

    typedef logic [11:0] coord_t;

    // a pixel arrives as two bus words
    typedef union packed {
        struct packed {
            logic [7:0] red;
            logic [3:0] green_hi;
        } first_half;
        struct packed {
            logic [3:0] green_lo;
            logic [7:0] blue;
        } second_half;
    } capture_word_u;

endpackage

`default_nettype wire

// File: design/raster_if.sv
`default_nettype none

interface raster_if;
    import video_capture_pkg::*;

    coord_t raw_x;
    coord_t raw_y;
    logic   add_line;
    logic   is_pal;
    logic   free_run;
    // one clock at hsync fall or free-run wrap
    logic   line_start;

    modport timing (
        output raw_x, raw_y, add_line, is_pal, free_run, line_start
    );

    modport pixel (
        input raw_x, raw_y, add_line, is_pal, free_run, line_start
    );

endinterface

`default_nettype wire

// File: design/pixel_if.sv
`default_nettype none

interface pixel_if;
    import video_capture_pkg::*;

    // pix_x, pix_y are aligned with the rgb registers
    coord_t     pix_x;
    coord_t     pix_y;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    // aligned with the bus word currently on data_in, capture mode only
    logic       in_window;
    logic       frame_start;
    logic       line_start;

    modport source (
        output pix_x, pix_y, red, green, blue, in_window, frame_start, line_start
    );

    modport monitor (
        input pix_x, pix_y, red, green, blue, in_window, frame_start, line_start
    );
endinterface

`default_nettype wire

// File: design/sync_timing.sv
`default_nettype none

module sync_timing (
    input  logic        clock,
    input  logic        reset,
    input  logic        hsync_n,
    input  logic        vsync_n,
    input  logic        generate_timing,
    raster_if.timing    raster,
    output logic        resync,
    output logic [23:0] timing_info
);
    import video_capture_pkg::*;

    logic   hsync_q1;
    logic   hsync_q2;
    logic   vsync_q1;
    logic   vsync_q2;
    logic   hsync_fall;
    logic   vsync_fall;
    logic   x_wrap;
    logic   y_wrap;
    logic   known_frame;
    coord_t raw_x;
    coord_t raw_y;
    coord_t line_length;
    coord_t line_count;
    logic   add_line_q;
    logic   is_pal_q;

    // syncs idle high
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hsync_q1 <= 1'b1;
            hsync_q2 <= 1'b1;
            vsync_q1 <= 1'b1;
            vsync_q2 <= 1'b1;
        end else begin
            hsync_q1 <= hsync_n;
            hsync_q2 <= hsync_q1;
            vsync_q1 <= vsync_n;
            vsync_q2 <= vsync_q1;
        end
    end

    assign hsync_fall = hsync_q2 & ~hsync_q1;
    assign vsync_fall = vsync_q2 & ~vsync_q1;
    assign x_wrap     = raw_x == coord_t'(raw_width - 1);
    assign y_wrap     = raw_y == coord_t'(raw_height - 1);

    assign known_frame = raw_y == coord_t'(lines_240p)
                      || raw_y == coord_t'(lines_480)
                      || raw_y == coord_t'(lines_pal);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            raw_x       <= '0;
            raw_y       <= '0;
            line_length <= '0;
            line_count  <= '0;
            add_line_q  <= 1'b0;
            is_pal_q    <= 1'b0;
            resync      <= 1'b1;
        end else if (generate_timing) begin
            // own 1716x525 raster, syncs ignored
            if (x_wrap) begin
                raw_x <= '0;
                if (y_wrap) begin
                    raw_y  <= '0;
                    resync <= 1'b0;
                end else begin
                    raw_y <= raw_y + 1'b1;
                end
            end else begin
                raw_x <= raw_x + 1'b1;
            end
        end else if (hsync_fall) begin
            line_length <= raw_x;
            raw_x       <= '0;
            if (vsync_fall) begin
                // frame length decides the mode and whether the output must resync
                line_count <= raw_y;
                raw_y      <= '0;
                add_line_q <= raw_y == coord_t'(lines_240p);
                is_pal_q   <= raw_y == coord_t'(lines_pal);
                resync     <= ~known_frame;
            end else begin
                raw_y <= raw_y + 1'b1;
            end
        end else begin
            raw_x <= raw_x + 1'b1;
        end
    end

    assign timing_info       = {line_length, line_count};
    assign raster.raw_x      = raw_x;
    assign raster.raw_y      = raw_y;
    assign raster.add_line   = add_line_q;
    assign raster.is_pal     = is_pal_q;
    assign raster.free_run   = generate_timing;
    assign raster.line_start = generate_timing ? x_wrap : hsync_fall;

endmodule

`default_nettype wire

// File: design/pixel_assembler.sv
`default_nettype none

module pixel_assembler (
    input  logic                             clock,
    input  logic                             reset,
    input  video_capture_pkg::capture_word_u data_in,
    input  logic                             generate_video,
    input  logic signed [7:0]                h_shift,
    raster_if.pixel                          raster,
    pixel_if.source                          pix
);
    import video_capture_pkg::*;

    coord_t     hstart;
    coord_t     vstart;
    coord_t     height;
    coord_t     win_start;
    coord_t     x_count;
    coord_t     y_count;
    logic       at_start;
    logic       first_line;
    logic       window;
    logic       pattern;
    logic [7:0] red_buf;
    logic [3:0] green_hi_buf;

    function automatic logic [23:0] bar_colour(input coord_t x);
        logic [2:0] mask;
        mask = 3'b000;
        for (int i = 0; i < 8; i++) begin
            if (x >= coord_t'(bar_offset + i * bar_width)
                    && x < coord_t'(bar_offset + (i + 1) * bar_width)) begin
                mask = bar_colours[i];
            end
        end
        return {{8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}} & {3{8'(bar_level)}};
    endfunction

    always_comb begin
        if (raster.add_line) begin
            hstart = coord_t'(hstart_240p);
            vstart = coord_t'(vstart_240p);
            height = coord_t'(height_240p);
        end else if (raster.is_pal) begin
            hstart = coord_t'(hstart_240p);
            vstart = coord_t'(vstart_pal);
            height = coord_t'(height_pal);
        end else begin
            hstart = coord_t'(hstart_480);
            vstart = coord_t'(vstart_480);
            height = coord_t'(height_480);
        end
    end

    assign win_start  = hstart + {{4{h_shift[7]}}, h_shift};
    assign at_start   = raster.raw_x == win_start;
    assign first_line = raster.raw_y == vstart;
    assign window     = x_count < coord_t'(area_width) && y_count < height;
    assign pattern    = generate_video | raster.free_run;

    assign pix.in_window  = window & ~pattern;
    assign pix.line_start = raster.line_start;

    ////////////////////////////////////////////////////////////
    // visible grid, counters saturate at all ones
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x_count         <= '1;
            y_count         <= '1;
            pix.frame_start <= 1'b0;
        end else begin
            pix.frame_start <= at_start & first_line;
            if (at_start) begin
                x_count <= '0;
                if (first_line) begin
                    y_count <= '0;
                end else if (y_count != '1) begin
                    y_count <= y_count + 1'b1;
                end
            end else if (raster.raw_x[0] && x_count != '1) begin
                x_count <= x_count + 1'b1;
            end
        end
    end

    // first half of the pixel lands on odd raw clocks
    always_ff @(posedge clock) begin
        if (raster.raw_x[0]) begin
            red_buf      <= data_in.first_half.red;
            green_hi_buf <= data_in.first_half.green_hi;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pix.pix_x <= '1;
            pix.pix_y <= '1;
            pix.red   <= '0;
            pix.green <= '0;
            pix.blue  <= '0;
        end else begin
            pix.pix_x <= x_count;
            pix.pix_y <= y_count;
            if (!window) begin
                pix.red   <= '0;
                pix.green <= '0;
                pix.blue  <= '0;
            end else if (!raster.raw_x[0]) begin
                if (pattern) begin
                    {pix.red, pix.green, pix.blue} <= bar_colour(x_count);
                end else begin
                    pix.red   <= red_buf;
                    pix.green <= {green_hi_buf, data_in.second_half.green_lo};
                    pix.blue  <= data_in.second_half.blue;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/line_monitor.sv
`default_nettype none

module line_monitor (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [11:0]               data_in,
    input  logic                      extent_clear,
    pixel_if.monitor                  pix,
    output logic [23:0]               pin_ok,
    output video_capture_pkg::coord_t extent_first,
    output video_capture_pkg::coord_t extent_last
);
    import video_capture_pkg::*;

    logic [10:0] stuck_high_flags;
    logic [10:0] stuck_low_flags;
    coord_t      first_x;
    coord_t      last_x;
    logic        non_black;

    assign non_black = |{pix.red, pix.green, pix.blue};

    // neighbour pair check, 10 or 01 proves the two pins differ
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stuck_high_flags <= '0;
            stuck_low_flags  <= '0;
            pin_ok           <= '0;
        end else if (pix.frame_start) begin
            pin_ok           <= {2'b00, stuck_high_flags, stuck_low_flags};
            stuck_high_flags <= '0;
            stuck_low_flags  <= '0;
        end else if (pix.in_window) begin
            for (int i = 0; i < 11; i++) begin
                if (data_in[i +: 2] == 2'b10) stuck_high_flags[i] <= 1'b1;
                if (data_in[i +: 2] == 2'b01) stuck_low_flags[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            first_x      <= '1;
            last_x       <= '0;
            extent_first <= '1;
            extent_last  <= '0;
        end else if (extent_clear) begin
            first_x      <= '1;
            last_x       <= '0;
            extent_first <= '1;
            extent_last  <= '0;
        end else if (pix.line_start) begin
            // publish and start over for the next line
            extent_first <= first_x;
            extent_last  <= last_x;
            first_x      <= '1;
            last_x       <= '0;
        end else if (non_black) begin
            if (pix.pix_x < first_x) first_x <= pix.pix_x;
            if (pix.pix_x > last_x) last_x <= pix.pix_x;
        end
    end

endmodule

`default_nettype wire

// File: design/video_capture_top.sv
`default_nettype none

module video_capture_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [11:0]               data_in,
    input  logic                      hsync_n,
    input  logic                      vsync_n,
    input  logic                      generate_video,
    input  logic                      generate_timing,
    input  logic signed [7:0]         h_shift,
    input  logic                      extent_clear,
    output logic [7:0]                red,
    output logic [7:0]                green,
    output logic [7:0]                blue,
    output video_capture_pkg::coord_t counter_x,
    output video_capture_pkg::coord_t counter_y,
    output logic                      add_line,
    output logic                      is_pal,
    output logic                      resync,
    output logic [23:0]               pin_ok,
    output logic [23:0]               timing_info,
    output video_capture_pkg::coord_t extent_first,
    output video_capture_pkg::coord_t extent_last
);

    raster_if raster ();
    pixel_if  pix ();

    sync_timing u_sync_timing (
        .clock           (clock),
        .reset           (reset),
        .hsync_n         (hsync_n),
        .vsync_n         (vsync_n),
        .generate_timing (generate_timing),
        .raster          (raster.timing),
        .resync          (resync),
        .timing_info     (timing_info)
    );

    pixel_assembler u_pixel_assembler (
        .clock          (clock),
        .reset          (reset),
        .data_in        (data_in),
        .generate_video (generate_video),
        .h_shift        (h_shift),
        .raster         (raster.pixel),
        .pix            (pix.source)
    );

    line_monitor u_line_monitor (
        .clock        (clock),
        .reset        (reset),
        .data_in      (data_in),
        .extent_clear (extent_clear),
        .pix          (pix.monitor),
        .pin_ok       (pin_ok),
        .extent_first (extent_first),
        .extent_last  (extent_last)
    );

    assign red       = pix.red;
    assign green     = pix.green;
    assign blue      = pix.blue;
    assign counter_x = pix.pix_x;
    assign counter_y = pix.pix_y;
    assign add_line  = raster.add_line;
    assign is_pal    = raster.is_pal;

endmodule

`default_nettype wire

// File: dv/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clock
);

    initial clock = 1'b0;

    // period of 10
    always #5 clock = ~clock;

endmodule

`default_nettype wire

// File: dv/video_capture_tb.sv
`default_nettype none

module video_capture_tb;
    import video_capture_pkg::*;

    // frame lengths of all tests plus one more free-run frame to reach the sampled row
    localparam int total_clocks = 10 + 50 * 400 + (263 + 625 + 300 + 263) * 400 + 4 * 400
                                + 2 * 263 * 400 + 3 * 1000 + 2 * raw_width * raw_height
                                + 100000;

    logic              clock;
    logic              reset;
    logic [11:0]       data_in;
    logic              hsync_n;
    logic              vsync_n;
    logic              generate_video;
    logic              generate_timing;
    logic signed [7:0] h_shift;
    logic              extent_clear;
    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;
    coord_t            counter_x;
    coord_t            counter_y;
    logic              add_line;
    logic              is_pal;
    logic              resync;
    logic [23:0]       pin_ok;
    logic [23:0]       timing_info;
    coord_t            extent_first;
    coord_t            extent_last;

    // bus word generator state
    int          word_mode;
    logic [11:0] word_a;
    logic [11:0] word_b;
    int          ext_p1;
    int          ext_p2;
    bit          ext_active;
    int          win_start;

    // outputs seen on each clock of the last line
    logic [23:0] sample_rgb [0:999];
    coord_t      sample_x [0:999];

    clock_gen clock_gen0 (.clock(clock));

    video_capture_top dut0 (
        .clock           (clock),
        .reset           (reset),
        .data_in         (data_in),
        .hsync_n         (hsync_n),
        .vsync_n         (vsync_n),
        .generate_video  (generate_video),
        .generate_timing (generate_timing),
        .h_shift         (h_shift),
        .extent_clear    (extent_clear),
        .red             (red),
        .green           (green),
        .blue            (blue),
        .counter_x       (counter_x),
        .counter_y       (counter_y),
        .add_line        (add_line),
        .is_pal          (is_pal),
        .resync          (resync),
        .pin_ok          (pin_ok),
        .timing_info     (timing_info),
        .extent_first    (extent_first),
        .extent_last     (extent_last)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("[ERROR] %s: %s expected %0h, actual %0h", test, what, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic step(input logic hs, input logic vs, input logic [11:0] word);
        @(posedge clock);
        #1;
        hsync_n = hs;
        vsync_n = vs;
        data_in = word;
    endtask

    function automatic logic [11:0] bus_word(input int rx);
        case (word_mode)
            1: return rx[0] ? word_a : word_b;
            2: return rx[0] ? 12'haaa : 12'h555;
            3: begin
                if (ext_active && rx >= win_start + 2 * ext_p1
                        && rx <= win_start + 2 * ext_p2 + 1) begin
                    return 12'hfff;
                end
                return 12'h000;
            end
            default: return 12'h000;
        endcase
    endfunction

    // word at clock c is seen by the DUT with raw_x = c - 2
    task automatic send_line(input bit vs_low, input int len);
        int rx;
        for (int c = 0; c < len; c++) begin
            rx = (c >= 2) ? c - 2 : len - 2 + c;
            step(c >= 20, ~vs_low, bus_word(rx));
            sample_rgb[c] = {red, green, blue};
            sample_x[c]   = counter_x;
        end
    endtask

    task automatic send_frame(input int lines, input int len);
        for (int i = 0; i < lines; i++) begin
            send_line(i == 0, len);
        end
    endtask

    // bars from left to right are red, green, blue, white, black, cyan, yellow and magenta
    function automatic logic [23:0] bar_rule(input int x);
        logic [7:0] l;
        l = 8'(bar_level);
        if (x < bar_offset || x >= bar_offset + 8 * bar_width) return 24'h0;
        case ((x - bar_offset) / bar_width)
            0: return {l, 8'h00, 8'h00};
            1: return {8'h00, l, 8'h00};
            2: return {8'h00, 8'h00, l};
            3: return {l, l, l};
            4: return 24'h0;
            5: return {8'h00, l, l};
            6: return {l, l, 8'h00};
            default: return {l, 8'h00, l};
        endcase
    endfunction

    // a 10 neighbour pair marks the high flag and 01 marks the low flag
    function automatic logic [21:0] pair_flags(input logic [11:0] w);
        logic [10:0] hi;
        logic [10:0] lo;
        for (int i = 0; i < 11; i++) begin
            hi[i] = w[i + 1] & ~w[i];
            lo[i] = ~w[i + 1] & w[i];
        end
        return {hi, lo};
    endfunction

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic pixel_assembly();
        capture_word_u a;
        capture_word_u b;
        logic [23:0]   expected;
        word_a    = 12'($urandom());
        word_b    = 12'($urandom());
        word_mode = 1;
        a         = word_a;
        b         = word_b;
        expected  = {a.first_half.red, a.first_half.green_hi,
                     b.second_half.green_lo, b.second_half.blue};
        // 480-line window after reset
        for (int line = 0; line < 50; line++) begin
            send_line(line == 0, 400);
            if (line < vstart_480) begin
                for (int c = 0; c < 400; c++) begin
                    check_value("pixel_assembly", "rgb before visible area",
                                32'h0, 32'(sample_rgb[c]));
                end
            end else begin
                check_value("pixel_assembly", "rgb mid-line", 32'(expected),
                            32'(sample_rgb[352]));
                // pixel p ends with the word at clock hstart + 2p + 3 and shows a clock later
                check_value("pixel_assembly", "counter_x mid-line",
                            32'((352 - 4 - hstart_480) / 2), 32'(sample_x[352]));
                check_value("pixel_assembly", "counter_y", 32'(line - vstart_480),
                            32'(counter_y));
            end
        end
    endtask

    // flags follow the length of the frame before the last vsync
    task automatic frame_classes();
        word_mode = 0;
        send_frame(263, 400);
        send_frame(625, 400);
        check_value("frame_classes", "add_line", 32'd1, 32'(add_line));
        check_value("frame_classes", "is_pal", 32'd0, 32'(is_pal));
        check_value("frame_classes", "resync", 32'd0, 32'(resync));
        check_value("frame_classes", "line count", 32'd262, 32'(timing_info[11:0]));
        check_value("frame_classes", "line length", 32'd399, 32'(timing_info[23:12]));
        send_frame(300, 400);
        check_value("frame_classes", "is_pal", 32'd1, 32'(is_pal));
        check_value("frame_classes", "resync", 32'd0, 32'(resync));
        send_frame(263, 400);
        check_value("frame_classes", "resync", 32'd1, 32'(resync));
        check_value("frame_classes", "add_line", 32'd0, 32'(add_line));
        check_value("frame_classes", "is_pal", 32'd0, 32'(is_pal));
    endtask

    task automatic line_extent();
        ext_p1     = int'($urandom_range(0, 29));
        ext_p2     = ext_p1 + int'($urandom_range(1, 30));
        win_start  = hstart_240p;
        word_mode  = 3;
        ext_active = 0;
        send_line(1'b1, 400);
        ext_active = 1;
        send_line(1'b0, 400);
        ext_active = 0;
        send_line(1'b0, 400);
        check_value("line_extent", "extent_first", 32'(ext_p1), 32'(extent_first));
        check_value("line_extent", "extent_last", 32'(ext_p2), 32'(extent_last));
        extent_clear = 1'b1;
        step(1'b1, 1'b1, 12'h000);
        extent_clear = 1'b0;
        check_value("line_extent", "cleared extent_first", 32'hfff, 32'(extent_first));
        check_value("line_extent", "cleared extent_last", 32'h0, 32'(extent_last));
    endtask

    task automatic pin_check();
        logic [23:0] expected;
        word_mode = 2;
        send_frame(263, 400);
        send_frame(263, 400);
        expected = {2'b00, pair_flags(12'haaa) | pair_flags(12'h555)};
        check_value("pin_check", "pin_ok", 32'(expected), 32'(pin_ok));
    endtask

    task automatic test_pattern();
        int x;
        word_mode      = 0;
        generate_video = 1'b1;
        send_line(1'b1, 1000);
        for (int line = 1; line < 3; line++) begin
            send_line(1'b0, 1000);
            for (int c = 0; c < 1000; c++) begin
                x = int'(sample_x[c]);
                if (x < area_width) begin
                    check_value("test_pattern", "bar colour", 32'(bar_rule(x)),
                                32'(sample_rgb[c]));
                end
            end
        end
        generate_video = 1'b0;
    endtask

    task automatic free_run();
        logic [7:0] seen;
        int         x;
        // the short pattern frame is an unknown length, so its vsync sets resync
        send_line(1'b1, 400);
        check_value("free_run", "resync before free-run", 32'd1, 32'(resync));
        generate_timing = 1'b1;
        repeat (raw_width * raw_height) step(1'b1, 1'b1, 12'h000);
        check_value("free_run", "resync", 32'd0, 32'(resync));
        while (counter_y != 12'd100) step(1'b1, 1'b1, 12'h000);
        seen = 8'h00;
        while (counter_y == 12'd100) begin
            x = int'(counter_x);
            if (x < area_width) begin
                check_value("free_run", "bar colour", 32'(bar_rule(x)),
                            32'({red, green, blue}));
                if (x >= bar_offset && x < bar_offset + 8 * bar_width) begin
                    seen[(x - bar_offset) / bar_width] = 1'b1;
                end
            end
            step(1'b1, 1'b1, 12'h000);
        end
        check_value("free_run", "bars seen", 32'hff, 32'(seen));
    endtask

    ////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////

    initial begin
        #(total_clocks * 10);
        $display("[ERROR] watchdog: the tests did not finish in time");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hd716_eab4));
        reset           = 1'b1;
        data_in         = 12'h000;
        hsync_n         = 1'b1;
        vsync_n         = 1'b1;
        generate_video  = 1'b0;
        generate_timing = 1'b0;
        h_shift         = 8'sd0;
        extent_clear    = 1'b0;
        word_mode       = 0;
        ext_active      = 0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        pixel_assembly();
        frame_classes();
        line_extent();
        pin_check();
        test_pattern();
        free_run();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/video_capture_pkg.sv
design/raster_if.sv
design/pixel_if.sv
design/sync_timing.sv
design/pixel_assembler.sv
design/line_monitor.sv
design/video_capture_top.sv
dv/clock_gen.sv
dv/video_capture_tb.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module video_capture_tb -f filelist.f -o video_capture_sim

./obj_dir/video_capture_sim | tee sim.log

grep -q "^test passed$" sim.log
